// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int pc_step = 4;
    localparam int reset_pc = 0;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // instruction field positions
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;
    localparam int rd_lsb = 7;
    localparam int rd_msb = 11;
    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;
    localparam int rs1_lsb = 15;
    localparam int rs1_msb = 19;
    localparam int rs2_lsb = 20;
    localparam int rs2_msb = 24;
    localparam int funct7_lsb = 25;
    localparam int funct7_msb = 31;

    // funct3 codes for the alu group
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct3 codes for branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000; // sub vs add on op_reg

    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

endpackage

// File: rtl/fetch_stage.sv
module fetch_stage (
    input  logic clk,
    input  logic rst,

    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,

    input  logic id_stall,
    input  logic redirect_valid,
    input  cpu_pkg::word_t redirect_pc,

    output logic if_valid,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr
);
    import cpu_pkg::*;

    word_t pc;

    assign imem_addr = pc; // async read with data back in the same cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= word_t'(reset_pc);
            if_valid <= 1'b0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
            if_valid <= 1'b0; // slot behind a taken transfer is dropped
        end else if (!id_stall) begin
            pc <= pc + word_t'(pc_step);
            if_valid <= 1'b1;
        end
    end

    // fetch register payload
    always_ff @(posedge clk) begin
        if (!id_stall && !redirect_valid) begin
            if_pc <= pc;
            if_instr <= imem_data;
        end
    end

    // decode holds while stalled, so the word it is looking at must not move
    a_stall_holds: assert property (
        @(posedge clk) disable iff (rst)
        id_stall && !redirect_valid |=> $stable(if_valid) && $stable(if_pc)
            && $stable(if_instr)
    );

endmodule

// File: rtl/decode_stage.sv
module decode_stage (
    input  logic clk,
    input  logic rst,

    input  logic if_valid,
    input  cpu_pkg::word_t if_pc,
    input  cpu_pkg::word_t if_instr,
    output logic id_stall,

    output logic redirect_valid,
    output cpu_pkg::word_t redirect_pc,

    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t rs1_data,
    input  cpu_pkg::word_t rs2_data,

    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic ex_write_en,

    output logic id_valid,
    output cpu_pkg::word_t id_pc,
    output cpu_pkg::alu_op_e id_alu_op,
    output cpu_pkg::word_t id_operand_a,
    output cpu_pkg::word_t id_operand_b,
    output cpu_pkg::reg_addr_t id_rd,
    output logic id_write_en,
    output logic id_illegal
);
    import cpu_pkg::*;

    opcode_e opcode;
    reg_addr_t rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;
    logic legal;
    logic uses_rs1;
    logic uses_rs2;
    logic write_en;
    alu_op_e alu_op;
    word_t operand_a;
    word_t operand_b;
    logic branch_hit;
    logic hazard;
    logic accept;

    // shared by op_imm and op_reg
    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic sub);
        case (f3)
            f3_add: return sub ? alu_sub : alu_add;
            f3_sll: return alu_sll;
            f3_slt: return alu_slt;
            f3_xor: return alu_xor;
            f3_srl: return alu_srl;
            f3_or: return alu_or;
            f3_and: return alu_and;
            default: return alu_add; // sltu not supported
        endcase
    endfunction

    assign opcode = opcode_e'(if_instr[opcode_msb:opcode_lsb]);
    assign rd = if_instr[rd_msb:rd_lsb];
    assign funct3 = if_instr[funct3_msb:funct3_lsb];
    assign funct7 = if_instr[funct7_msb:funct7_lsb];
    assign rs1_addr = if_instr[rs1_msb:rs1_lsb];
    assign rs2_addr = if_instr[rs2_msb:rs2_lsb];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_u = {if_instr[31:12], 12'b0};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                    if_instr[30:21], 1'b0};

    always_comb begin
        legal = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        write_en = 1'b1;
        alu_op = alu_add;
        operand_a = rs1_data;
        operand_b = imm_i;
        case (opcode)
            op_imm: begin
                uses_rs1 = 1'b1;
                alu_op = funct3_op(funct3, 1'b0);
            end
            op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                operand_b = rs2_data;
                alu_op = funct3_op(funct3, funct7 == f7_sub);
            end
            op_lui: begin
                operand_a = '0;
                operand_b = imm_u;
                alu_op = alu_pass_b;
            end
            op_auipc: begin
                operand_a = if_pc;
                operand_b = imm_u;
            end
            op_jal: begin
                operand_a = if_pc; // link = pc + 4
                operand_b = word_t'(pc_step);
            end
            op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                write_en = 1'b0;
            end
            default: begin
                legal = 1'b0;
                write_en = 1'b0;
            end
        endcase
    end

    assign branch_hit = (funct3 == f3_beq && rs1_data == rs2_data)
                     || (funct3 == f3_bne && rs1_data != rs2_data);

    // only the instruction in execute is not yet visible through the regfile
    assign hazard = ex_write_en && ((uses_rs1 && rs1_addr == ex_rd)
                                 || (uses_rs2 && rs2_addr == ex_rd));
    assign id_stall = if_valid && hazard;
    assign accept = if_valid && !hazard;

    assign redirect_valid = accept && (opcode == op_jal || (opcode == op_branch && branch_hit));
    assign redirect_pc = if_pc + ((opcode == op_jal) ? imm_j : imm_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= accept; // bubble while stalled
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= if_pc;
        id_alu_op <= alu_op;
        id_operand_a <= operand_a;
        id_operand_b <= operand_b;
        id_rd <= rd;
        id_write_en <= write_en;
        id_illegal <= !legal;
    end

    a_no_redirect_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |-> !id_stall
    );

    // the transfer moves on and the fetch slot behind it is gone
    a_redirect_flushes: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |=> id_valid && !if_valid
    );

endmodule

// File: rtl/register_file.sv
module register_file (
    input  logic clk,
    input  logic rst,

    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t rs1_data,
    output cpu_pkg::word_t rs2_data,

    input  logic write_en,
    input  cpu_pkg::reg_addr_t write_addr,
    input  cpu_pkg::word_t write_data
);
    import cpu_pkg::*;

    word_t regs [2**reg_addr_width];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (write_en && write_addr == addr) begin
            return write_data; // write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
    input  logic clk,
    input  logic rst,

    input  logic id_valid,
    input  cpu_pkg::word_t id_pc,
    input  cpu_pkg::alu_op_e id_alu_op,
    input  cpu_pkg::word_t id_operand_a,
    input  cpu_pkg::word_t id_operand_b,
    input  cpu_pkg::reg_addr_t id_rd,
    input  logic id_write_en,
    input  logic id_illegal,

    output cpu_pkg::reg_addr_t ex_rd,
    output logic ex_write_en,

    output logic retire_valid,
    output cpu_pkg::word_t retire_pc,
    output cpu_pkg::reg_addr_t retire_rd,
    output cpu_pkg::word_t retire_data,
    output logic retire_illegal
);
    import cpu_pkg::*;

    word_t alu_result;
    logic [reg_addr_width-1:0] shamt;
    logic writes;

    assign shamt = id_operand_b[reg_addr_width-1:0];

    always_comb begin
        case (id_alu_op)
            alu_add: alu_result = id_operand_a + id_operand_b;
            alu_sub: alu_result = id_operand_a - id_operand_b;
            alu_and: alu_result = id_operand_a & id_operand_b;
            alu_or: alu_result = id_operand_a | id_operand_b;
            alu_xor: alu_result = id_operand_a ^ id_operand_b;
            alu_slt: alu_result = word_t'($signed(id_operand_a) < $signed(id_operand_b));
            alu_sll: alu_result = id_operand_a << shamt;
            alu_srl: alu_result = id_operand_a >> shamt;
            alu_pass_b: alu_result = id_operand_b;
            default: alu_result = '0;
        endcase
    end

    // x0 targets count as no write
    assign writes = id_write_en && !id_illegal && id_rd != '0;

    // instruction sitting in execute as seen by the decode interlock
    assign ex_rd = id_rd;
    assign ex_write_en = id_valid && writes;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= id_valid;
        end
    end

    // retire record that also feeds the regfile write port
    always_ff @(posedge clk) begin
        retire_pc <= id_pc;
        retire_rd <= writes ? id_rd : '0;
        retire_data <= writes ? alu_result : '0;
        retire_illegal <= id_illegal;
    end

    a_illegal_no_write: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid && retire_illegal |-> retire_rd == '0 && retire_data == '0
    );

endmodule

// File: rtl/pipeline_cpu.sv
module pipeline_cpu (
    input  logic clk,
    input  logic rst,

    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,

    output logic retire_valid,
    output cpu_pkg::word_t retire_pc,
    output cpu_pkg::reg_addr_t retire_rd,
    output cpu_pkg::word_t retire_data,
    output logic retire_illegal
);
    import cpu_pkg::*;

    // fetch to decode
    logic if_valid;
    word_t if_pc;
    word_t if_instr;
    logic id_stall;
    logic redirect_valid;
    word_t redirect_pc;

    // decode to regfile
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;

    // decode to execute
    logic id_valid;
    word_t id_pc;
    alu_op_e id_alu_op;
    word_t id_operand_a;
    word_t id_operand_b;
    reg_addr_t id_rd;
    logic id_write_en;
    logic id_illegal;
    reg_addr_t ex_rd;
    logic ex_write_en;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .id_stall(id_stall), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .id_stall(id_stall), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_rd(ex_rd), .ex_write_en(ex_write_en), .id_valid(id_valid), .id_pc(id_pc),
        .id_alu_op(id_alu_op), .id_operand_a(id_operand_a), .id_operand_b(id_operand_b),
        .id_rd(id_rd), .id_write_en(id_write_en), .id_illegal(id_illegal)
    );

    // retire record doubles as the write port
    register_file u_regs (
        .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .write_en(retire_valid),
        .write_addr(retire_rd), .write_data(retire_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .id_valid(id_valid), .id_pc(id_pc), .id_alu_op(id_alu_op),
        .id_operand_a(id_operand_a), .id_operand_b(id_operand_b), .id_rd(id_rd),
        .id_write_en(id_write_en), .id_illegal(id_illegal), .ex_rd(ex_rd),
        .ex_write_en(ex_write_en), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data), .retire_illegal(retire_illegal)
    );

endmodule

// File: tests/pipeline_cpu_tb.sv
module pipeline_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int program_words = 32;
    localparam int record_count = 20;
    localparam int record_words = 4; // pc, rd, data, illegal
    localparam int case_words = program_words + record_count * record_words;
    localparam int reset_cycles = 5;
    localparam int retire_timeout = 20;
    localparam int first_retire_latency = 3;
    localparam logic [31:0] nop_word = 32'h00000013; // addi x0, x0, 0

    logic clk;
    logic rst;
    word_t imem_addr;
    word_t imem_data;
    logic retire_valid;
    word_t retire_pc;
    reg_addr_t retire_rd;
    word_t retire_data;
    logic retire_illegal;

    logic [31:0] cases_mem [case_words];

    pipeline_cpu dut (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .retire_illegal(retire_illegal)
    );

    always #20 clk = ~clk;

    // program words sit at the start of the case file
    function automatic logic [31:0] program_word(input word_t addr);
        if ($isunknown(addr)) begin
            return nop_word;
        end
        if (addr[31:2] < program_words) begin
            return cases_mem[addr[31:2]];
        end
        return nop_word; // past the end of the program
    endfunction

    // pc only moves on a rising edge, so the word is settled well before the next one
    always @(negedge clk) begin
        imem_data <= program_word(imem_addr);
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // counts falling edges until a retire shows up
    task automatic wait_retire(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (retire_valid !== 1'b1 && cycles < retire_timeout);
        if (retire_valid !== 1'b1) begin
            stop_with_failure($sformatf("no instruction retired within %0d cycles",
                                        retire_timeout));
        end
    endtask

    initial begin
        int waited;
        int base;
        string tag;

        clk = 1'b0;
        rst = 1'b1;
        imem_data = nop_word;

        $readmemh("tests/pipeline_cases.mem", cases_mem);
        if ($isunknown(cases_mem[case_words-1])) begin
            stop_with_failure("the case file is missing or shorter than expected");
        end

        repeat (reset_cycles) begin
            @(negedge clk);
            check_equal("retire_valid in reset", 32'd0, 32'(retire_valid));
        end
        check_equal("first fetch address", 32'd0, imem_addr);
        rst = 1'b0;

        for (int i = 0; i < record_count; i++) begin
            base = program_words + i * record_words;
            wait_retire(waited);
            if (i == 0) begin
                check_equal("first retire latency", first_retire_latency, waited);
            end
            tag = $sformatf("record %0d", i);
            check_equal({tag, " pc"}, cases_mem[base], retire_pc);
            check_equal({tag, " rd"}, cases_mem[base+1], 32'(retire_rd));
            check_equal({tag, " data"}, cases_mem[base+2], retire_data);
            check_equal({tag, " illegal"}, cases_mem[base+3], 32'(retire_illegal));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: pipeline_cpu.f
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/pipeline_cpu.sv
tests/pipeline_cpu_tb.sv

// File: tests/pipeline_cases.mem
// first 32 words: program at 0x00, 8 words per line
// then one expected retire record per line: pc rd data illegal
00500093 FFD08113 123451B7 00001217 00700013 002002B3 40208333 001373B3
0033E433 001444B3 FF800513 001525B3 00209633 002556B3 00228663 00100713
00200713 00511463 00C007EF 00300713 00400713 FFFFFFFF 00178813 0000006F
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000000 01 00000005 0
00000004 02 00000002 0
00000008 03 12345000 0
0000000C 04 0000100C 0
00000010 00 00000000 0
00000014 05 00000002 0
00000018 06 00000003 0
0000001C 07 00000001 0
00000020 08 12345001 0
00000024 09 12345004 0
00000028 0A FFFFFFF8 0
0000002C 0B 00000001 0
00000030 0C 00000014 0
00000034 0D 3FFFFFFE 0
00000038 00 00000000 0
00000044 00 00000000 0
00000048 0F 0000004C 0
00000054 00 00000000 1
00000058 10 0000004D 0
0000005C 00 00000000 0
